// File: common/rd_resp_cfg.svh
`ifndef RD_RESP_CFG_SVH
`define RD_RESP_CFG_SVH

// R channel data width in bits
`define RR_DATA_W 64

// transaction id width and id count
`define RR_ID_W 2
`define RR_NUM_IDS 4

// burst length field, beats minus one
`define RR_LEN_W 8

// memory beat buffer entries
`define RR_FIFO_DEPTH 2

`endif

// File: common/rd_resp_pkg.sv
`include "rd_resp_cfg.svh"

package rd_resp_pkg;

    // one beat of read data
    typedef logic [`RR_DATA_W-1:0] data_t;

    typedef logic [`RR_ID_W-1:0] id_t;

    // beats minus one, as on the AR channel
    typedef logic [`RR_LEN_W-1:0] len_t;

    // log2 of bytes per beat
    typedef logic [1:0] beat_size_t;

    // AXI read response codes
    typedef enum logic [1:0] {
        resp_okay   = 2'd0,
        resp_slverr = 2'd2
    } resp_t;

endpackage

// File: id_table/id_table.sv
`include "rd_resp_cfg.svh"

module id_table (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     cmd_valid,
    input  rd_resp_pkg::id_t         cmd_id,
    input  rd_resp_pkg::len_t        cmd_len,
    input  rd_resp_pkg::beat_size_t  cmd_size,
    input  logic                     pop,
    input  rd_resp_pkg::id_t         head_id,
    output rd_resp_pkg::len_t        head_len,
    output rd_resp_pkg::beat_size_t  head_size,
    output rd_resp_pkg::len_t        head_count
);

    rd_resp_pkg::len_t       len_q   [`RR_NUM_IDS];
    rd_resp_pkg::beat_size_t size_q  [`RR_NUM_IDS];
    rd_resp_pkg::len_t       count_q [`RR_NUM_IDS];

    logic              head_wrap;
    rd_resp_pkg::len_t head_count_nxt;

    // lookup for the beat at the FIFO head
    assign head_len   = len_q[head_id];
    assign head_size  = size_q[head_id];
    assign head_count = count_q[head_id];

    assign head_wrap = (head_count == head_len); // last beat of this burst

    always_comb begin
        if (head_wrap) begin
            head_count_nxt = '0;
        end else begin
            head_count_nxt = head_count + 1'b1;
        end
    end

    // burst shape, written by the command port only
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < `RR_NUM_IDS; i++) begin
                len_q[i]  <= '0;
                size_q[i] <= '0;
            end
        end else if (cmd_valid) begin
            len_q[cmd_id]  <= cmd_len;
            size_q[cmd_id] <= cmd_size;
        end
    end

    // beat counters
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < `RR_NUM_IDS; i++) begin
                count_q[i] <= '0;
            end
        end else begin
            if (pop) begin
                count_q[head_id] <= head_count_nxt;
            end
            if (cmd_valid) begin
                count_q[cmd_id] <= '0; // new command restarts the count
            end
        end
    end

endmodule

// File: hdl/beat_fifo.sv
`include "rd_resp_cfg.svh"

module beat_fifo (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                mem_valid,
    input  rd_resp_pkg::id_t    mem_id,
    input  rd_resp_pkg::data_t  mem_data,
    input  logic                mem_err,
    input  logic                pop,
    output logic                mem_ready,
    output logic                head_valid,
    output rd_resp_pkg::id_t    head_id,
    output rd_resp_pkg::data_t  head_data,
    output logic                head_err
);

    rd_resp_pkg::id_t   id_mem   [`RR_FIFO_DEPTH];
    rd_resp_pkg::data_t data_mem [`RR_FIFO_DEPTH];
    logic               err_mem  [`RR_FIFO_DEPTH];

    logic [$clog2(`RR_FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(`RR_FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(`RR_FIFO_DEPTH+1)-1:0] fill;

    logic push;

    assign mem_ready  = (fill != `RR_FIFO_DEPTH);
    assign head_valid = (fill != 0);
    assign push       = mem_valid && mem_ready;

    assign head_id   = id_mem[rd_ptr];
    assign head_data = data_mem[rd_ptr];
    assign head_err  = err_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            id_mem[wr_ptr]   <= mem_id;
            data_mem[wr_ptr] <= mem_data;
            err_mem[wr_ptr]  <= mem_err;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop) begin
                fill <= fill + 1'b1;
            end else if (pop && !push) begin
                fill <= fill - 1'b1;
            end
        end
    end

endmodule

// File: hdl/lane_aligner.sv
module lane_aligner (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     head_valid,
    input  rd_resp_pkg::id_t         head_id,
    input  rd_resp_pkg::data_t       head_data,
    input  logic                     head_err,
    input  rd_resp_pkg::len_t        head_len,
    input  rd_resp_pkg::beat_size_t  head_size,
    input  rd_resp_pkg::len_t        head_count,
    input  logic                     r_ready,
    output logic                     pop,
    output logic                     r_valid,
    output rd_resp_pkg::data_t       r_data,
    output rd_resp_pkg::id_t         r_id,
    output rd_resp_pkg::resp_t       r_resp,
    output logic                     r_last,
    output logic                     done,
    output rd_resp_pkg::id_t         done_id
);

    rd_resp_pkg::data_t placed;
    logic               r_fire;

    // output register free or draining this cycle
    assign pop    = head_valid && (!r_valid || r_ready);
    assign r_fire = r_valid && r_ready;

    // narrow beat moves to the lanes picked by the beat number
    always_comb begin
        unique case (head_size)
            2'd0: placed = rd_resp_pkg::data_t'(head_data[7:0]) << {head_count[2:0], 3'b000};
            2'd1: placed = rd_resp_pkg::data_t'(head_data[15:0]) << {head_count[1:0], 4'b0000};
            2'd2: placed = rd_resp_pkg::data_t'(head_data[31:0]) << {head_count[0], 5'b00000};
            default: placed = head_data; // full width beat
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            r_valid <= 1'b0;
            r_last  <= 1'b0;
            done    <= 1'b0;
        end else begin
            if (pop) begin
                r_valid <= 1'b1;
                r_last  <= (head_count == head_len);
            end else if (r_ready) begin
                r_valid <= 1'b0;
                r_last  <= 1'b0;
            end
            done <= r_fire && r_last; // one cycle after the last beat leaves
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            r_data <= placed;
            r_id   <= head_id;
            r_resp <= head_err ? rd_resp_pkg::resp_slverr : rd_resp_pkg::resp_okay;
        end
        if (r_fire && r_last) begin
            done_id <= r_id;
        end
    end

endmodule

// File: hdl/rd_resp_top.sv
module rd_resp_top (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     cmd_valid,
    input  rd_resp_pkg::id_t         cmd_id,
    input  rd_resp_pkg::len_t        cmd_len,
    input  rd_resp_pkg::beat_size_t  cmd_size,
    input  logic                     mem_valid,
    input  rd_resp_pkg::id_t         mem_id,
    input  rd_resp_pkg::data_t       mem_data,
    input  logic                     mem_err,
    output logic                     mem_ready,
    output logic                     r_valid,
    output rd_resp_pkg::data_t       r_data,
    output rd_resp_pkg::id_t         r_id,
    output rd_resp_pkg::resp_t       r_resp,
    output logic                     r_last,
    input  logic                     r_ready,
    output logic                     done,
    output rd_resp_pkg::id_t         done_id
);

    logic                    head_valid;
    rd_resp_pkg::id_t        head_id;
    rd_resp_pkg::data_t      head_data;
    logic                    head_err;
    rd_resp_pkg::len_t       head_len;
    rd_resp_pkg::beat_size_t head_size;
    rd_resp_pkg::len_t       head_count;
    logic                    pop;

    id_table id_table_i (
        .clk, .n_rst,
        .cmd_valid, .cmd_id, .cmd_len, .cmd_size,
        .pop, .head_id,
        .head_len, .head_size, .head_count
    );

    beat_fifo beat_fifo_i (
        .clk, .n_rst,
        .mem_valid, .mem_id, .mem_data, .mem_err,
        .pop,
        .mem_ready, .head_valid, .head_id, .head_data, .head_err
    );

    lane_aligner lane_aligner_i (
        .clk, .n_rst,
        .head_valid, .head_id, .head_data, .head_err,
        .head_len, .head_size, .head_count,
        .r_ready,
        .pop,
        .r_valid, .r_data, .r_id, .r_resp, .r_last,
        .done, .done_id
    );

endmodule

// File: dv/tb_clkgen.sv
module tb_clkgen #(
    parameter int period     = 40,
    parameter int rst_cycles = 8
) (
    output logic clk,
    output logic n_rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        n_rst = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
    end

endmodule

// File: dv/rd_resp_tb.sv
module rd_resp_tb;

    localparam int clk_period = 40;
    localparam int rst_cycles = 8;
    localparam int max_rows   = 16;
    localparam int no_err     = -1;

    logic                    clk;
    logic                    n_rst;
    logic                    cmd_valid;
    rd_resp_pkg::id_t        cmd_id;
    rd_resp_pkg::len_t       cmd_len;
    rd_resp_pkg::beat_size_t cmd_size;
    logic                    mem_valid;
    rd_resp_pkg::id_t        mem_id;
    rd_resp_pkg::data_t      mem_data;
    logic                    mem_err;
    logic                    mem_ready;
    logic                    r_valid;
    rd_resp_pkg::data_t      r_data;
    rd_resp_pkg::id_t        r_id;
    rd_resp_pkg::resp_t      r_resp;
    logic                    r_last;
    logic                    r_ready;
    logic                    done;
    rd_resp_pkg::id_t        done_id;

    // stimulus table, rows sharing a group run interleaved
    int                 n_rows;
    int                 max_grp;
    int                 total_beats;
    int                 t_grp  [max_rows];
    int                 t_id   [max_rows];
    int                 t_len  [max_rows];
    int                 t_size [max_rows];
    rd_resp_pkg::data_t t_base [max_rows];
    int                 t_err  [max_rows];

    // expected beats, one ring per id
    rd_resp_pkg::data_t exp_data [4][256];
    logic [1:0]         exp_resp [4][256];
    logic               exp_last [4][256];
    int                 wr_ptr   [4];
    int                 rd_ptr   [4];

    int                 err_count;
    int                 sent_total;
    int                 recv_total;
    logic [31:0]        lfsr_state;
    logic               table_ready;
    logic               mon_on;
    logic               hold_pending;
    rd_resp_pkg::data_t hold_data;
    logic               exp_done;
    rd_resp_pkg::id_t   exp_done_id;

    tb_clkgen #(.period(clk_period), .rst_cycles(rst_cycles)) clkgen_i (.clk, .n_rst);

    rd_resp_top dut_i (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function logic take_bit();
        lfsr_state = lfsr_step(lfsr_state);
        return lfsr_state[0];
    endfunction

    // lane placement rule for a narrow beat
    function automatic rd_resp_pkg::data_t place_beat(input rd_resp_pkg::data_t d,
                                                      input int size, input int idx);
        int                 bytes;
        int                 lane;
        rd_resp_pkg::data_t mask;
        bytes = 1 << size;
        lane  = idx % (8 / bytes);
        mask  = (bytes == 8) ? '1 : ((64'd1 << (bytes * 8)) - 64'd1);
        return (d & mask) << (lane * bytes * 8);
    endfunction

    task automatic add_row(input int grp, input int id, input int len, input int size,
                           input rd_resp_pkg::data_t base, input int err);
        t_grp[n_rows]  = grp;
        t_id[n_rows]   = id;
        t_len[n_rows]  = len;
        t_size[n_rows] = size;
        t_base[n_rows] = base;
        t_err[n_rows]  = err;
        if (grp > max_grp) max_grp = grp;
        total_beats += len + 1;
        n_rows++;
    endtask

    task automatic compare_value(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
        if (got !== exp) begin
            $display("Fail %s expected %h got %h", name, exp, got);
            err_count++;
        end
    endtask

    task automatic push_expect(input int id, input rd_resp_pkg::data_t d,
                               input logic err, input logic last);
        exp_data[id][wr_ptr[id] % 256] = d;
        exp_resp[id][wr_ptr[id] % 256] = err ? 2'd2 : 2'd0;
        exp_last[id][wr_ptr[id] % 256] = last;
        wr_ptr[id]++;
        sent_total++;
    endtask

    task automatic check_beat();
        int slot;
        if (rd_ptr[r_id] == wr_ptr[r_id]) begin
            $display("unexpected beat returned on ID %0d", r_id);
            err_count++;
        end else begin
            slot = rd_ptr[r_id] % 256;
            compare_value("r_data", exp_data[r_id][slot], r_data);
            compare_value("r_resp", exp_resp[r_id][slot], r_resp);
            compare_value("r_last", exp_last[r_id][slot], r_last);
            exp_done    = exp_last[r_id][slot]; // model's last flag, not the DUT's
            exp_done_id = r_id;
            rd_ptr[r_id]++;
        end
        recv_total++;
    endtask

    task automatic step_cycle();
        @(negedge clk);
        cmd_valid = 1'b0;
        mem_valid = 1'b0;
        r_ready   = take_bit() | take_bit(); // high three cycles in four
    endtask

    task automatic run_group(input int g);
        int sent [max_rows];
        int left;
        int cur;
        int idx;
        left = 0;
        for (int k = 0; k < n_rows; k++) begin
            sent[k] = 0;
            if (t_grp[k] == g) begin
                step_cycle();
                cmd_valid = 1'b1;
                cmd_id    = t_id[k];
                cmd_len   = t_len[k];
                cmd_size  = t_size[k];
                left += t_len[k] + 1;
            end
        end
        cur = 0;
        while (left > 0) begin
            while (t_grp[cur] != g || sent[cur] > t_len[cur]) cur = (cur + 1) % n_rows;
            step_cycle();
            idx       = sent[cur];
            mem_valid = take_bit() | take_bit();
            mem_id    = t_id[cur];
            mem_data  = t_base[cur] + idx;
            mem_err   = (idx == t_err[cur]);
            @(posedge clk);
            if (mem_valid && mem_ready) begin
                push_expect(t_id[cur], place_beat(mem_data, t_size[cur], idx),
                            idx == t_err[cur], idx == t_len[cur]);
                sent[cur]++;
                left--;
                cur = (cur + 1) % n_rows; // next id gets the next beat
            end
        end
        while (recv_total < sent_total) step_cycle();
        repeat (3) step_cycle(); // room for the last done pulse
    endtask

    always @(posedge clk) begin
        if (mon_on) begin
            if (hold_pending) begin
                if (!r_valid) begin
                    $display("r_valid dropped before r_ready was seen");
                    err_count++;
                end else begin
                    compare_value("r_data", hold_data, r_data); // stalled payload
                end
            end
            compare_value("done", exp_done, done);
            if (exp_done && done) compare_value("done_id", exp_done_id, done_id);
            exp_done = 1'b0;
            if (r_valid && r_ready) check_beat();
            hold_pending = r_valid && !r_ready;
            hold_data    = r_data;
        end
    end

    initial begin
        wait (table_ready);
        #((total_beats * 60 + rst_cycles) * clk_period);
        $display("timeout, the DUT stopped returning read beats");
        $display("tests failed");
        $finish;
    end

    initial begin
        cmd_valid = 1'b0;
        cmd_id    = '0;
        cmd_len   = '0;
        cmd_size  = '0;
        mem_valid = 1'b0;
        mem_id    = '0;
        mem_data  = '0;
        mem_err   = 1'b0;
        r_ready   = 1'b0;
        table_ready  = 1'b0;
        lfsr_state   = 32'h9535_13f0;
        mon_on       = 1'b0;
        hold_pending = 1'b0;
        exp_done     = 1'b0;
        err_count    = 0;
        sent_total   = 0;
        recv_total   = 0;
        n_rows       = 0;
        max_grp      = 0;
        total_beats  = 0;
        for (int i = 0; i < 4; i++) begin
            wr_ptr[i] = 0;
            rd_ptr[i] = 0;
        end

        add_row(0, 0, 3, 3, 64'h0123_4567_89ab_cdef, no_err);
        add_row(1, 1, 9, 0, 64'h1111_2222_3333_44a0, no_err); // byte lanes wrap
        add_row(2, 2, 5, 1, 64'h5555_6666_7777_b000, no_err);
        add_row(3, 3, 4, 2, 64'h9999_aaaa_c0de_0100, no_err);
        add_row(4, 0, 5, 3, 64'hdead_beef_0000_1000, 2);
        add_row(4, 1, 2, 0, 64'h0000_0000_0000_00e0, 0);
        add_row(5, 0, 7, 0, 64'h0a0b_0c0d_0e0f_1010, no_err);
        add_row(5, 1, 5, 1, 64'h2222_3333_4444_5500, 3);
        add_row(5, 2, 3, 2, 64'h6666_7777_8888_9900, no_err);
        add_row(5, 3, 2, 3, 64'hfeed_face_cafe_0000, 1);
        add_row(6, 2, 15, 2, 64'h1357_9bdf_2468_ace0, no_err);
        add_row(6, 3, 11, 1, 64'h8642_0000_fdb9_7500, 6);
        table_ready = 1'b1;

        wait (n_rst === 1'b1);
        @(negedge clk);
        compare_value("r_valid", 0, r_valid);
        compare_value("r_last", 0, r_last);
        compare_value("done", 0, done);
        compare_value("mem_ready", 1, mem_ready);
        mon_on = 1'b1;

        for (int g = 0; g <= max_grp; g++) run_group(g);

        for (int i = 0; i < 4; i++) begin
            if (rd_ptr[i] != wr_ptr[i]) begin
                $display("ID %0d is missing %0d read beats", i, wr_ptr[i] - rd_ptr[i]);
                err_count++;
            end
        end
        $display("%0d beats sent, %0d returned, %0d errors", sent_total, recv_total, err_count);
        if (err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: rd_resp.f
+incdir+common
common/rd_resp_pkg.sv
id_table/id_table.sv
hdl/beat_fifo.sv
hdl/lane_aligner.sv
hdl/rd_resp_top.sv
dv/tb_clkgen.sv
dv/rd_resp_tb.sv

// File: Bender.yml
package:
  name: rd_resp

sources:
  - include_dirs:
      - common
    files:
      - common/rd_resp_pkg.sv
      - id_table/id_table.sv
      - hdl/beat_fifo.sv
      - hdl/lane_aligner.sv
      - hdl/rd_resp_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/tb_clkgen.sv
      - dv/rd_resp_tb.sv
